//--- include/pdp8_consts.svh
////////////////////////////////////////////////////////////////////////////
// PDP-8 mini CPU constants
// Word, memory and page sizes plus the auto-index window
////////////////////////////////////////////////////////////////////////////
`ifndef PDP8_CONSTS_SVH
`define PDP8_CONSTS_SVH

// Data and address words are the same width
`define PDP8_WORD_W 12

// Full 4K field, no extended memory
`define PDP8_MEM_WORDS 4096

// Offset inside a 128-word page
`define PDP8_OFFSET_W 7

// Locations that step on every indirect reference
`define PDP8_AUTO_LO 12'o0010
`define PDP8_AUTO_HI 12'o0017

`endif

//--- hdl/pdp8Pkg.sv
////////////////////////////////////////////////////////////////////////////
// PDP-8 mini CPU types
// Major states, opcodes, decoded instruction and per-cycle strobes
////////////////////////////////////////////////////////////////////////////
package pdp8Pkg;

  typedef enum logic [2:0] {
    stIdle, stFetch, stDefer, stAutoInc, stExec, stExec2
  } majorState;

  // Order matches IR[11:9]
  typedef enum logic [2:0] {
    opAnd, opTad, opIsz, opDca, opJms, opJmp, opIot, opOpr
  } opcode;

  typedef enum logic [1:0] {
    srcAc, srcPcPlus, srcIncData
  } memSource;

  typedef struct packed {
    opcode op;
    logic  indirect;
    logic  autoIndex;
    logic  oprGroup2;
    logic  halt;
  } instrInfo;

  // OPR micro-operations, group 1 and group 2 bits already separated
  typedef struct packed {
    logic cla;
    logic cll;
    logic cma;
    logic cml;
    logic iac;
    logic rar;
    logic ral;
    logic twice;
    logic sma;
    logic sza;
    logic snl;
    logic reverse;
    logic osr;
  } oprMicro;

  typedef struct packed {
    logic     irLoad;
    logic     pcInc;
    logic     pcLoadEa;
    logic     pcSkip;
    logic     maLoad;
    logic     maFromData;
    logic     maIncWrite;
    logic     memWrite;
    memSource memSrc;
    logic     acLoad;
    logic     linkLoad;
    logic     jmsStore;
    // Front-panel cycle, PC addresses memory and switches are the data
    logic     panel;
  } ctlStrobes;

endpackage

//--- hdl/majorStateSequencer.sv
////////////////////////////////////////////////////////////////////////////
// Major-state sequencer
// Run flip-flop and the fetch/defer/auto-index/execute cycle order
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module majorStateSequencer import pdp8Pkg::*; (
  input  logic      clk,
  input  logic      arstN,
  input  logic      start,
  input  instrInfo  info,
  output majorState state,
  output logic      running
);

  majorState nextState;
  logic      startRun;
  logic      haltNow;

  assign startRun = (state == stIdle) && start && !running;
  assign haltNow  = (state == stExec) && info.halt;

  always_comb begin
    nextState = state;
    case (state)
      stIdle:    if (startRun) nextState = stFetch;
      // Decode already sees the word being fetched
      stFetch: begin
        if (!info.indirect)     nextState = stExec;
        else if (info.autoIndex) nextState = stAutoInc;
        else                     nextState = stDefer;
      end
      stDefer:   nextState = stExec;
      stAutoInc: nextState = stExec;
      stExec: begin
        if (info.op == opIsz) nextState = stExec2;
        else if (haltNow)     nextState = stIdle;
        else                  nextState = stFetch;
      end
      stExec2:   nextState = stFetch;
      default:   nextState = stIdle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= stIdle;
      running <= 1'b0;
    end else begin
      state <= nextState;
      if (startRun) begin
        running <= 1'b1;
      end else if (haltNow) begin
        running <= 1'b0;
      end
    end
  end

  aStateLegal: assert property (@(posedge clk) disable iff (!arstN)
    !$isunknown(state) && state inside {stIdle, stFetch, stDefer, stAutoInc, stExec, stExec2})
    else $error("major state out of range");

  // Any non-idle cycle belongs to a running program
  aRunOnly: assert property (@(posedge clk) disable iff (!arstN)
    (state != stIdle) |-> running)
    else $error("sequencer active while halted");

endmodule

//--- hdl/instructionDecoder.sv
////////////////////////////////////////////////////////////////////////////
// Instruction decoder
// Opcode, addressing mode, auto-index test and OPR micro-op bits
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pdp8_consts.svh"

module instructionDecoder import pdp8Pkg::*; (
  input  logic [`PDP8_WORD_W-1:0] ir,
  output instrInfo                info,
  output oprMicro                 micro
);

  logic                    memRef;
  logic                    isOpr;
  logic                    group1;
  logic                    group2;
  logic [`PDP8_WORD_W-1:0] zeroPageAddr;

  assign memRef = ~(ir[11] & ir[10]);
  assign isOpr  = (ir[11:9] == 3'b111);
  assign group1 = isOpr & ~ir[8];
  // Group 3 shares bit 8 but only honors CLA here
  assign group2 = isOpr & ir[8] & ~ir[0];

  // Auto-index only through page-zero references
  assign zeroPageAddr = {{(`PDP8_WORD_W - `PDP8_OFFSET_W){1'b0}}, ir[`PDP8_OFFSET_W-1:0]};

  always_comb begin
    info.op        = opcode'(ir[11:9]);
    info.indirect  = memRef & ir[8];
    info.autoIndex = memRef & ir[8] & ~ir[`PDP8_OFFSET_W]
                     & (zeroPageAddr >= `PDP8_AUTO_LO)
                     & (zeroPageAddr <= `PDP8_AUTO_HI);
    info.oprGroup2 = isOpr & ir[8];
    info.halt      = group2 & ir[1];
  end

  always_comb begin
    micro.cla     = isOpr & ir[7];
    // Group 1 layout
    micro.cll     = group1 & ir[6];
    micro.cma     = group1 & ir[5];
    micro.cml     = group1 & ir[4];
    micro.rar     = group1 & ir[3];
    micro.ral     = group1 & ir[2];
    micro.twice   = group1 & ir[1];
    micro.iac     = group1 & ir[0];
    // Group 2 layout
    micro.sma     = group2 & ir[6];
    micro.sza     = group2 & ir[5];
    micro.snl     = group2 & ir[4];
    micro.reverse = group2 & ir[3];
    micro.osr     = group2 & ir[2];
  end

endmodule

//--- hdl/memRefControl.sv
////////////////////////////////////////////////////////////////////////////
// Cycle control
// Builds the control strobes for each major state and instruction,
// including the front-panel load and deposit cycles
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module memRefControl import pdp8Pkg::*; (
  input  majorState state,
  input  instrInfo  info,
  input  logic      incZero,
  input  logic      skipTaken,
  input  logic      panelLoad,
  input  logic      panelDeposit,
  output ctlStrobes strobes
);

  always_comb begin
    strobes        = '0;
    strobes.memSrc = srcAc;
    case (state)
      stIdle: begin
        // Load address wins over deposit
        if (panelLoad) begin
          strobes.panel    = 1'b1;
          strobes.pcLoadEa = 1'b1;
        end else if (panelDeposit) begin
          strobes.panel    = 1'b1;
          strobes.memWrite = 1'b1;
          strobes.pcInc    = 1'b1;
        end
      end
      stFetch: begin
        strobes.irLoad = 1'b1;
        strobes.pcInc  = 1'b1;
        strobes.maLoad = 1'b1;
      end
      // Pointer becomes the operand address
      stDefer: begin
        strobes.maFromData = 1'b1;
      end
      stAutoInc: begin
        strobes.memWrite   = 1'b1;
        strobes.memSrc     = srcIncData;
        strobes.maIncWrite = 1'b1;
      end
      stExec: begin
        case (info.op)
          opAnd: strobes.acLoad = 1'b1;
          opTad: begin
            strobes.acLoad   = 1'b1;
            strobes.linkLoad = 1'b1;
          end
          // Deposit then clear
          opDca: begin
            strobes.memWrite = 1'b1;
            strobes.memSrc   = srcAc;
            strobes.acLoad   = 1'b1;
          end
          opJms: begin
            strobes.memWrite = 1'b1;
            strobes.memSrc   = srcPcPlus;
            strobes.jmsStore = 1'b1;
          end
          opJmp: strobes.pcLoadEa = 1'b1;
          opOpr: begin
            strobes.acLoad   = 1'b1;
            strobes.linkLoad = ~info.oprGroup2;
            strobes.pcSkip   = info.oprGroup2 & skipTaken;
          end
          // ISZ reads here, IOT does nothing
          default: ;
        endcase
      end
      stExec2: begin
        strobes.memWrite = 1'b1;
        strobes.memSrc   = srcIncData;
        strobes.pcSkip   = incZero;
      end
      default: ;
    endcase
  end

endmodule

//--- hdl/addressPath.sv
////////////////////////////////////////////////////////////////////////////
// Address path
// PC, IR and memory address register, effective address and the
// memory-data incrementer used by ISZ and auto-index
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pdp8_consts.svh"

module addressPath import pdp8Pkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  input  ctlStrobes               strobes,
  input  logic [`PDP8_WORD_W-1:0] readData,
  input  logic [`PDP8_WORD_W-1:0] switchReg,
  output logic [`PDP8_WORD_W-1:0] ir,
  output logic [`PDP8_WORD_W-1:0] memAddr,
  output logic [`PDP8_WORD_W-1:0] incData,
  output logic                    incZero,
  output logic [`PDP8_WORD_W-1:0] pc
);

  localparam int W   = `PDP8_WORD_W;
  localparam int OFF = `PDP8_OFFSET_W;

  logic [W-1:0]     irReg;
  logic [W-1:0]     maReg;
  logic [W-OFF-1:0] eaPage;
  logic [W-1:0]     directEa;

  // Fetch bypass so decode sees the new instruction in its own cycle
  assign ir = strobes.irLoad ? readData : irReg;

  // Page of the instruction itself, PC still points at it during fetch
  assign eaPage   = ir[OFF] ? pc[W-1:OFF] : '0;
  assign directEa = {eaPage, ir[OFF-1:0]};

  assign memAddr = (strobes.irLoad || strobes.panel) ? pc : maReg;

  assign incData = readData + 1'b1;
  assign incZero = (incData == '0);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
    end else if (strobes.pcLoadEa) begin
      pc <= strobes.panel ? switchReg : maReg;
    end else if (strobes.jmsStore) begin
      // Subroutine body starts after the return slot
      pc <= maReg + 1'b1;
    end else if (strobes.pcInc || strobes.pcSkip) begin
      pc <= pc + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      irReg <= '0;
      maReg <= '0;
    end else begin
      if (strobes.irLoad) irReg <= readData;
      if (strobes.maLoad) begin
        maReg <= directEa;
      end else if (strobes.maFromData) begin
        maReg <= readData;
      end else if (strobes.maIncWrite) begin
        maReg <= incData;
      end
    end
  end

endmodule

//--- hdl/coreMemory.sv
////////////////////////////////////////////////////////////////////////////
// Core memory
// 4K words, asynchronous read, write on the clock edge
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pdp8_consts.svh"

module coreMemory (
  input  logic                    clk,
  input  logic [`PDP8_WORD_W-1:0] addr,
  input  logic [`PDP8_WORD_W-1:0] writeData,
  input  logic                    write,
  output logic [`PDP8_WORD_W-1:0] readData
);

  logic [`PDP8_WORD_W-1:0] mem [`PDP8_MEM_WORDS];

  // Same address for read and write, so a write shows up next cycle
  assign readData = mem[addr];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[addr] <= writeData;
    end
  end

  // An unknown strobe would corrupt an unknown location
  aWriteKnown: assert property (@(posedge clk) !$isunknown(write))
    else $error("memory write strobe unknown");

endmodule

//--- hdl/accumulatorUnit.sv
////////////////////////////////////////////////////////////////////////////
// Accumulator unit
// AC and link with AND/TAD, OPR clear/OR/complement/increment/rotate
// chain and the group 2 skip test
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pdp8_consts.svh"

module accumulatorUnit import pdp8Pkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  input  ctlStrobes               strobes,
  input  opcode                   op,
  input  oprMicro                 micro,
  input  logic [`PDP8_WORD_W-1:0] readData,
  input  logic [`PDP8_WORD_W-1:0] switchReg,
  output logic [`PDP8_WORD_W-1:0] acc,
  output logic                    link,
  output logic                    skipTaken
);

  localparam int W = `PDP8_WORD_W;

  logic [W-1:0] tadSum;
  logic         tadCarry;
  logic [W-1:0] clrAcc;
  logic         clrLink;
  logic [W-1:0] orAcc;
  logic [W-1:0] cmaAcc;
  logic         cmlLink;
  logic [W-1:0] incAcc;
  logic         incCarry;
  logic [W:0]   rotIn;
  logic [W:0]   rotOut;
  logic         anySkip;

  assign {tadCarry, tadSum} = {1'b0, acc} + {1'b0, readData};

  // OPR chain in PDP-8 event order
  assign clrAcc             = micro.cla ? '0 : acc;
  assign clrLink            = micro.cll ? 1'b0 : link;
  assign orAcc              = micro.osr ? (clrAcc | switchReg) : clrAcc;
  assign cmaAcc             = micro.cma ? ~orAcc : orAcc;
  assign cmlLink            = micro.cml ? ~clrLink : clrLink;
  assign {incCarry, incAcc} = {1'b0, cmaAcc} + {{W{1'b0}}, micro.iac};
  assign rotIn              = {cmlLink ^ incCarry, incAcc};

  always_comb begin
    if (micro.rar) begin
      rotOut = micro.twice ? {rotIn[1:0], rotIn[W:2]} : {rotIn[0], rotIn[W:1]};
    end else if (micro.ral) begin
      rotOut = micro.twice ? {rotIn[W-2:0], rotIn[W:W-1]} : {rotIn[W-1:0], rotIn[W]};
    end else begin
      rotOut = rotIn;
    end
  end

  // Reverse sense inverts the OR, giving the AND of the inverted tests
  assign anySkip   = (micro.sma & acc[W-1]) | (micro.sza & (acc == '0)) | (micro.snl & link);
  assign skipTaken = micro.reverse ? ~anySkip : anySkip;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      acc  <= '0;
      link <= 1'b0;
    end else begin
      if (strobes.acLoad) begin
        case (op)
          opAnd:   acc <= acc & readData;
          opTad:   acc <= tadSum;
          opDca:   acc <= '0;
          opOpr:   acc <= rotOut[W-1:0];
          default: acc <= acc;
        endcase
      end
      if (strobes.linkLoad) begin
        if (op == opTad) begin
          link <= link ^ tadCarry;
        end else if (op == opOpr) begin
          link <= rotOut[W];
        end
      end
    end
  end

  // Fetch cycle carries the instruction, never an operand
  aNoAcInFetch: assert property (@(posedge clk) disable iff (!arstN)
    strobes.irLoad |-> !strobes.acLoad)
    else $error("accumulator load during fetch");

endmodule

//--- hdl/pdp8Top.sv
////////////////////////////////////////////////////////////////////////////
// PDP-8 mini CPU top level
// Sequencer, decode, control, address path, memory and accumulator
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pdp8_consts.svh"

module pdp8Top import pdp8Pkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic [`PDP8_WORD_W-1:0] switchReg,
  input  logic                    loadAddr,
  input  logic                    deposit,
  input  logic                    start,
  output logic [`PDP8_WORD_W-1:0] acc,
  output logic                    link,
  output logic [`PDP8_WORD_W-1:0] pc,
  output logic                    running
);

  majorState                 state;
  instrInfo                  info;
  oprMicro                   micro;
  ctlStrobes                 strobes;
  logic [`PDP8_WORD_W-1:0]   ir;
  logic [`PDP8_WORD_W-1:0]   memAddr;
  logic [`PDP8_WORD_W-1:0]   readData;
  logic [`PDP8_WORD_W-1:0]   writeData;
  logic [`PDP8_WORD_W-1:0]   incData;
  logic                      incZero;
  logic                      skipTaken;
  logic                      panelLoad;
  logic                      panelDeposit;

  // Panel switches are dead while the CPU runs
  assign panelLoad    = loadAddr & ~running;
  assign panelDeposit = deposit & ~running;

  // Memory write data select
  assign writeData = strobes.panel                  ? switchReg :
                     (strobes.memSrc == srcPcPlus)  ? pc        :
                     (strobes.memSrc == srcIncData) ? incData   : acc;

  majorStateSequencer seq0 (
    .clk     (clk),
    .arstN   (arstN),
    .start   (start),
    .info    (info),
    .state   (state),
    .running (running)
  );

  instructionDecoder dec0 (
    .ir    (ir),
    .info  (info),
    .micro (micro)
  );

  memRefControl ctl0 (
    .state        (state),
    .info         (info),
    .incZero      (incZero),
    .skipTaken    (skipTaken),
    .panelLoad    (panelLoad),
    .panelDeposit (panelDeposit),
    .strobes      (strobes)
  );

  addressPath adr0 (
    .clk       (clk),
    .arstN     (arstN),
    .strobes   (strobes),
    .readData  (readData),
    .switchReg (switchReg),
    .ir        (ir),
    .memAddr   (memAddr),
    .incData   (incData),
    .incZero   (incZero),
    .pc        (pc)
  );

  coreMemory mem0 (
    .clk       (clk),
    .addr      (memAddr),
    .writeData (writeData),
    .write     (strobes.memWrite),
    .readData  (readData)
  );

  accumulatorUnit acu0 (
    .clk       (clk),
    .arstN     (arstN),
    .strobes   (strobes),
    .op        (info.op),
    .micro     (micro),
    .readData  (readData),
    .switchReg (switchReg),
    .acc       (acc),
    .link      (link),
    .skipTaken (skipTaken)
  );

endmodule

//--- verification/pdp8Checker.sv
////////////////////////////////////////////////////////////////////////////
// PDP-8 mini CPU checker
// Compares AC, link and PC after reset and each time a program halts
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pdp8_consts.svh"

module pdp8Checker (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic [`PDP8_WORD_W-1:0] acc,
  input  logic                    link,
  input  logic [`PDP8_WORD_W-1:0] pc,
  input  logic                    running,
  input  logic [`PDP8_WORD_W-1:0] expAcc,
  input  logic                    expLink,
  input  logic [`PDP8_WORD_W-1:0] expPc,
  input  int                      rowIdx,
  output int                      errorCount,
  output int                      checkCount
);

  task automatic compareValue(input string name, input logic [`PDP8_WORD_W-1:0] got,
                              input logic [`PDP8_WORD_W-1:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[FAIL] %0t ns row %0d %s: got %o, expected %o",
               $time, rowIdx, name, got, exp);
    end
  endtask

  initial begin
    errorCount = 0;
    checkCount = 0;
  end

  // Out of reset the CPU is halted with cleared registers
  always @(posedge arstN) begin
    @(negedge clk);
    compareValue("acc after reset", acc, '0);
    compareValue("link after reset", link, '0);
    compareValue("pc after reset", pc, '0);
    compareValue("running after reset", running, '0);
  end

  // Running drops on the edge that ends HLT, sample half a cycle later
  always @(negedge running) begin
    if (arstN === 1'b1) begin
      @(negedge clk);
      compareValue("acc", acc, expAcc);
      compareValue("link", link, expLink);
      compareValue("pc", pc, expPc);
    end
  end

endmodule

//--- verification/pdp8Tb.sv
////////////////////////////////////////////////////////////////////////////
// PDP-8 mini CPU testbench
// Loads short programs through the front panel, runs them to HLT and
// hands the expected AC, link and PC to the checker
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pdp8_consts.svh"

module pdp8Tb;

  localparam int W          = `PDP8_WORD_W;
  localparam int CLK_PERIOD = 4;
  localparam int MAX_ROWS   = 64;
  localparam int MARGIN_NS  = 400;

  typedef struct packed {
    logic [W-1:0]      startAddr;
    logic [3:0]        nProg;
    logic [7:0][W-1:0] prog;
    logic [W-1:0]      dataAddr;
    logic [2:0]        nData;
    logic [3:0][W-1:0] data;
    logic [W-1:0]      swVal;
    logic [W-1:0]      expAcc;
    logic              expLink;
    logic [W-1:0]      expPc;
    logic [15:0]       cycles;
  } testRow;

  logic         clk;
  logic         arstN;
  logic [W-1:0] switchReg;
  logic         loadAddr;
  logic         deposit;
  logic         start;
  logic [W-1:0] acc;
  logic         link;
  logic [W-1:0] pc;
  logic         running;
  logic [W-1:0] expAcc;
  logic         expLink;
  logic [W-1:0] expPc;
  int           curRow;
  int           checkErrors;
  int           checksDone;
  int           tbErrors;
  int           rowCount;
  int           totalCycles;
  logic         tableReady;
  logic [15:0]  lfsrState;
  testRow       rows [MAX_ROWS];
  testRow       cur;

  pdp8Top dut0 (
    .clk       (clk),
    .arstN     (arstN),
    .switchReg (switchReg),
    .loadAddr  (loadAddr),
    .deposit   (deposit),
    .start     (start),
    .acc       (acc),
    .link      (link),
    .pc        (pc),
    .running   (running)
  );

  pdp8Checker chk0 (
    .clk        (clk),
    .arstN      (arstN),
    .acc        (acc),
    .link       (link),
    .pc         (pc),
    .running    (running),
    .expAcc     (expAcc),
    .expLink    (expLink),
    .expPc      (expPc),
    .rowIdx     (curRow),
    .errorCount (checkErrors),
    .checkCount (checksDone)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] nextLfsr(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic takeBits(input int n, output logic [W-1:0] value);
    value = '0;
    for (int k = 0; k < n; k++) begin
      lfsrState = nextLfsr(lfsrState);
      value     = {value[W-2:0], lfsrState[0]};
    end
  endtask

  // Group 1 in event order: clear, complement, increment, rotate
  function automatic logic [W:0] group1Result(input logic [W-1:0] ir,
                                               input logic [W-1:0] acIn, input logic lIn);
    logic [W-1:0] a;
    logic         l;
    logic [W:0]   sum;
    int           turns;
    a = acIn;
    l = lIn;
    if (ir[7]) a = '0;
    if (ir[6]) l = 1'b0;
    if (ir[5]) a = ~a;
    if (ir[4]) l = ~l;
    if (ir[0]) begin
      sum = {1'b0, a} + 1;
      a   = sum[W-1:0];
      if (sum[W]) l = ~l;
    end
    turns = ir[1] ? 2 : 1;
    for (int k = 0; k < turns; k++) begin
      if (ir[3]) {l, a} = {a[0], l, a[W-1:1]};
      else if (ir[2]) {l, a} = {a, l};
    end
    return {l, a};
  endfunction

  // Reverse sense needs every selected condition to be false
  function automatic logic skipDecision(input logic [W-1:0] ir,
                                        input logic [W-1:0] a, input logic l);
    if (ir[3]) begin
      return (!ir[6] || !a[W-1]) && (!ir[5] || a != 0) && (!ir[4] || !l);
    end
    return (ir[6] && a[W-1]) || (ir[5] && a == 0) || (ir[4] && l);
  endfunction

  task automatic addRow(input logic [W-1:0] startAddr, input int nProg,
                        input logic [7:0][W-1:0] prog, input logic [W-1:0] dataAddr,
                        input int nData, input logic [3:0][W-1:0] data,
                        input logic [W-1:0] sw, input logic [W-1:0] eAcc, input logic eLink,
                        input logic [W-1:0] ePc, input int execCycles);
    rows[rowCount].startAddr = startAddr;
    rows[rowCount].nProg     = nProg;
    rows[rowCount].prog      = prog;
    rows[rowCount].dataAddr  = dataAddr;
    rows[rowCount].nData     = nData;
    rows[rowCount].data      = data;
    rows[rowCount].swVal     = sw;
    rows[rowCount].expAcc    = eAcc;
    rows[rowCount].expLink   = eLink;
    rows[rowCount].expPc     = ePc;
    // Panel loading costs two cycles per word plus the address loads
    rows[rowCount].cycles    = execCycles + 2 * (nProg + nData) + 8;
    totalCycles += rows[rowCount].cycles;
    rowCount++;
  endtask

  task automatic addGroup1Row(input logic [W-1:0] op);
    logic [W-1:0] operand;
    logic [W-1:0] linkBit;
    logic [W:0]   result;
    takeBits(W, operand);
    takeBits(1, linkBit);
    result = group1Result(op, operand, linkBit[0]);
    addRow(12'o0200, 5, {12'o7300, 12'o1050, linkBit[0] ? 12'o7020 : 12'o7000, op, 12'o7402},
           12'o0050, 1, operand, '0, result[W-1:0], result[W], 12'o0205, 14);
  endtask

  task automatic addGroup2Row(input logic [W-1:0] op, input logic [W-1:0] operand,
                              input logic linkBit, input logic [W-1:0] sw);
    logic [W-1:0] a;
    a = op[7] ? '0 : operand;
    if (op[2]) a = a | sw;
    addRow(12'o0200, 6,
           {12'o7300, 12'o1050, linkBit ? 12'o7020 : 12'o7000, op, 12'o7402, 12'o7402},
           12'o0050, 1, operand, sw, a, linkBit,
           skipDecision(op, operand, linkBit) ? 12'o0206 : 12'o0205, 16);
  endtask

  task automatic buildTable();
    // Panel load and deposit, then TAD and HLT
    addRow(12'o0200, 3, {12'o7300, 12'o1050, 12'o7402},
           12'o0050, 1, 12'o1234, '0, 12'o1234, 1'b0, 12'o0203, 10);
    // AND, TAD with carry, DCA and reload
    addRow(12'o0200, 4, {12'o7300, 12'o1050, 12'o0051, 12'o7402},
           12'o0050, 2, {12'o7070, 12'o3333}, '0, 12'o3030, 1'b0, 12'o0204, 12);
    addRow(12'o0200, 4, {12'o7300, 12'o1050, 12'o1051, 12'o7402},
           12'o0050, 2, {12'o6000, 12'o3000}, '0, 12'o1000, 1'b1, 12'o0204, 12);
    addRow(12'o0200, 6, {12'o7300, 12'o1050, 12'o1050, 12'o3052, 12'o1052, 12'o7402},
           12'o0050, 3, {12'o0123, 12'o0000, 12'o0000}, '0, 12'o0246, 1'b0, 12'o0206, 16);
    // JMS into 0210, return by JMP I, then add the stored return address
    addRow(12'o0200, 4, {12'o7300, 12'o4210, 12'o1210, 12'o7402},
           12'o0210, 4, {12'o0000, 12'o1213, 12'o5610, 12'o0055}, '0, 12'o0257, 1'b0,
           12'o0204, 20);
    addRow(12'o0200, 7, {12'o7300, 12'o5205, 12'o7402, 12'o7402, 12'o7402, 12'o1050,
           12'o7402}, 12'o0050, 1, 12'o0017, '0, 12'o0017, 1'b0, 12'o0207, 12);
    // Current page, indirect, auto-index through 0010
    addRow(12'o0200, 3, {12'o7300, 12'o1250, 12'o7402},
           12'o0250, 1, 12'o0456, '0, 12'o0456, 1'b0, 12'o0203, 10);
    addRow(12'o0200, 3, {12'o7300, 12'o1460, 12'o7402},
           12'o0060, 2, {12'o0061, 12'o0741}, '0, 12'o0741, 1'b0, 12'o0203, 12);
    addRow(12'o0200, 5, {12'o7300, 12'o1410, 12'o1410, 12'o1010, 12'o7402},
           12'o0010, 3, {12'o0010, 12'o0100, 12'o0200}, '0, 12'o0312, 1'b0, 12'o0205, 16);
    // ISZ from 7776 skips only on the wrap to zero
    addRow(12'o0200, 8, {12'o7300, 12'o2050, 12'o1051, 12'o2050, 12'o7402, 12'o1051,
           12'o1050, 12'o7402}, 12'o0050, 2, {12'o7776, 12'o0001}, '0, 12'o0002, 1'b0,
           12'o0210, 24);
    for (int pass = 0; pass < 2; pass++) begin
      addGroup1Row(12'o7200);
      addGroup1Row(12'o7100);
      addGroup1Row(12'o7040);
      addGroup1Row(12'o7020);
      addGroup1Row(12'o7001);
      addGroup1Row(12'o7004);
      addGroup1Row(12'o7010);
      addGroup1Row(12'o7006);
      addGroup1Row(12'o7012);
      addGroup1Row(12'o7041);
    end
    addGroup2Row(12'o7500, 12'o4000, 1'b0, '0);
    addGroup2Row(12'o7500, 12'o0001, 1'b0, '0);
    addGroup2Row(12'o7440, 12'o0000, 1'b0, '0);
    addGroup2Row(12'o7440, 12'o0005, 1'b0, '0);
    addGroup2Row(12'o7420, 12'o0001, 1'b1, '0);
    addGroup2Row(12'o7420, 12'o0001, 1'b0, '0);
    addGroup2Row(12'o7510, 12'o0001, 1'b0, '0);
    addGroup2Row(12'o7510, 12'o4000, 1'b0, '0);
    addGroup2Row(12'o7450, 12'o0005, 1'b0, '0);
    addGroup2Row(12'o7430, 12'o0003, 1'b0, '0);
    addGroup2Row(12'o7430, 12'o0003, 1'b1, '0);
    addGroup2Row(12'o7540, 12'o0000, 1'b0, '0);
    addGroup2Row(12'o7550, 12'o4000, 1'b0, '0);
    addGroup2Row(12'o7604, 12'o1111, 1'b0, 12'o5252);
    addGroup2Row(12'o7404, 12'o0101, 1'b1, 12'o1010);
  endtask

  // Panel tasks start and end 1 ns after a rising edge
  task automatic loadAddress(input logic [W-1:0] addr);
    switchReg = addr;
    loadAddr  = 1'b1;
    @(posedge clk);
    #1;
    loadAddr  = 1'b0;
  endtask

  task automatic depositWord(input logic [W-1:0] word);
    switchReg = word;
    deposit   = 1'b1;
    @(posedge clk);
    #1;
    deposit   = 1'b0;
  endtask

  task automatic runProgram();
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    while (running) begin
      @(posedge clk);
      #1;
    end
    // Idle cycle so the checker samples before the next row
    @(posedge clk);
    #1;
  endtask

  initial begin
    arstN       = 1'b0;
    switchReg   = '0;
    loadAddr    = 1'b0;
    deposit     = 1'b0;
    start       = 1'b0;
    expAcc      = '0;
    expLink     = 1'b0;
    expPc       = '0;
    curRow      = 0;
    tbErrors    = 0;
    rowCount    = 0;
    totalCycles = 0;
    tableReady  = 1'b0;
    lfsrState   = 16'd24872;
    buildTable();
    tableReady  = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    arstN = 1'b1;
    @(posedge clk);
    #1;
    for (int r = 0; r < rowCount; r++) begin
      cur     = rows[r];
      curRow  = r;
      expAcc  = cur.expAcc;
      expLink = cur.expLink;
      expPc   = cur.expPc;
      loadAddress(cur.startAddr);
      for (int i = 0; i < cur.nProg; i++) depositWord(cur.prog[cur.nProg - 1 - i]);
      if (cur.nData != 0) begin
        loadAddress(cur.dataAddr);
        for (int i = 0; i < cur.nData; i++) depositWord(cur.data[cur.nData - 1 - i]);
      end
      loadAddress(cur.startAddr);
      switchReg = cur.swVal;
      runProgram();
    end
    repeat (2) @(posedge clk);
    if (checksDone != 4 + 3 * rowCount) begin
      $display("Checker ran %0d checks where %0d were due", checksDone, 4 + 3 * rowCount);
      tbErrors++;
    end
    $display("Checks: %0d, errors: %0d", checksDone, checkErrors + tbErrors);
    if (checkErrors + tbErrors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Bound on the whole run from the rows' cycle budgets
  initial begin
    wait (tableReady);
    #(totalCycles * CLK_PERIOD + MARGIN_NS);
    $display("Watchdog expired: the program of row %0d did not halt", curRow);
    $display("Regression failed");
    $finish;
  end

endmodule

//--- pdp8Mini.f
+incdir+include
hdl/pdp8Pkg.sv
hdl/majorStateSequencer.sv
hdl/instructionDecoder.sv
hdl/memRefControl.sv
hdl/addressPath.sv
hdl/coreMemory.sv
hdl/accumulatorUnit.sv
hdl/pdp8Top.sv
verification/pdp8Checker.sv
verification/pdp8Tb.sv
